//--- sim.f
rtl/alu_pkg.sv
rtl/int_muldiv.sv
rtl/int_to_float.sv
rtl/float_to_int.sv
rtl/int_alu.sv
rtl/reg_file.sv
rtl/int_exec_unit.sv
verification/int_exec_unit_chk.sv
verification/int_exec_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execution unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f sim.f --top-module int_exec_unit_tb \
    --Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Build failed, see build.log"
    cat build.log
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -F -x -q "** PASS **" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed (exit status $status)"
exit 1

//--- verification/int_exec_unit_tb.sv
/* Testbench for the execution unit: clock, reset, LFSR stimulus, shadow registers,
   reference model and result comparison */
`timescale 1ns/1ps
`default_nettype none

module int_exec_unit_tb import alu_pkg::*; ();

    logic      clk;
    logic      reset;
    logic      cmd_valid;
    exec_cmd_t cmd;
    logic      load_en;
    reg_addr_t load_addr;
    word_t     load_data;
    logic      busy;
    logic      result_valid;
    word_t     result_data;
    alu_flag_t result_flag;

    word_t       shadow [16];
    logic [15:0] lfsr_q;
    logic [33:0] exp_q [$];
    string       name_q [$];

    int_exec_unit #(.NUM_REGS(16)) dut (.*);

    always #2 clk = ~clk;

    //////////////////////////////
    // Helpers
    //////////////////////////////
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_q[0];
            lfsr_q = lfsr_q >> 1;
            if (b)
                lfsr_q = lfsr_q ^ 16'hB400;
            r = {r[30:0], b};
        end
        return r;
    endfunction

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "Simulation stopped");
        end
    endtask

    function automatic word_t ref_itof(word_t a);
        word_t       mag;
        word_t       mant;
        word_t       rem;
        word_t       half;
        logic [7:0]  e;
        int          p;
        int          s;
        if (a == '0)
            return '0;
        mag = a[31] ? -a : a;
        p = 31;
        while (!mag[p])
            p--;
        e = 8'(127 + p);
        if (p <= 23) begin
            mant = mag << (23 - p);
        end else begin
            s = p - 23;
            mant = mag >> s;
            rem  = mag & ((32'd1 << s) - 32'd1);
            half = 32'd1 << (s - 1);
            // Nearest, ties to even
            if (rem > half || (rem == half && mant[0]))
                mant = mant + 32'd1;
            if (mant[24]) begin
                mant = mant >> 1;
                e = e + 8'd1;
            end
        end
        return {a[31], e, mant[22:0]};
    endfunction

    function automatic word_t ref_ftoi(word_t a);
        logic [7:0] e;
        word_t      mag;
        int         unb;
        e = a[30:23];
        if (e == 8'hFF && a[22:0] != '0)
            return 32'h7FFF_FFFF;
        if (e < 8'd127)
            return '0;
        if (e >= 8'd158)
            return a[31] ? 32'h8000_0000 : 32'h7FFF_FFFF;
        unb = int'(e) - 127;
        mag = {8'd0, 1'b1, a[22:0]};
        if (unb >= 23)
            mag = mag << (unb - 23);
        else
            mag = mag >> (23 - unb);
        return a[31] ? -mag : mag;
    endfunction

    // Expected {flag, result} from the opcode rules
    function automatic logic [33:0] ref_result(alu_op_t op, word_t a, word_t b);
        word_t       r;
        alu_flag_t   f;
        longint      s;
        f = '0;
        r = '0;
        s = 0;
        if (!op[3] && !op[2]) begin
            // Exact result in 64 bits, truncating division
            case (op[1:0])
                2'b00:   s = longint'($signed(a)) + longint'($signed(b));
                2'b01:   s = longint'($signed(a)) - longint'($signed(b));
                2'b10:   s = longint'($signed(a)) * longint'($signed(b));
                default: begin
                    if (b != '0)
                        s = longint'($signed(a)) / longint'($signed(b));
                end
            endcase
            r = word_t'(s);
            // Signed overflow when the exact result leaves the 32-bit range
            f[0] = (s > 64'sd2147483647) || (s < -64'sd2147483648);
            if (op[1:0] == 2'b11 && b == '0) begin
                r = '1;
                f = 2'b10;
            end
        end else if (!op[3]) begin
            case (op[1:0])
                2'b00:   r = ~a;
                2'b01:   r = a & b;
                2'b10:   r = a | b;
                default: r = a ^ b;
            endcase
        end else begin
            case (op[1:0])
                2'b00:   r = {b[15:0], a[15:0]};
                2'b01:   r = {a[31:16], b[15:0]};
                2'b10:   r = ref_itof(a);
                default: r = ref_ftoi(a);
            endcase
        end
        return {f, r};
    endfunction

    // Cycles from acceptance to result_valid, 0 where it varies
    function automatic int latency_of(alu_op_t op);
        if (!op[3])
            return op[2] ? 2 : (op[1] ? 35 : 3);
        case (op[1:0])
            2'b10:   return 0;
            2'b11:   return 3;
            default: return 2;
        endcase
    endfunction

    task automatic wait_idle();
        int cnt;
        cnt = 0;
        while (busy) begin
            @(posedge clk);
            #1;
            cnt++;
            if (cnt > 100)
                fail_run("Timeout waiting for busy to fall");
        end
    endtask

    task automatic load_reg(reg_addr_t addr, word_t data);
        wait_idle();
        load_en   = 1'b1;
        load_addr = addr;
        load_data = data;
        @(posedge clk);
        #1;
        load_en = 1'b0;
        shadow[addr] = data;
    endtask

    task automatic issue_cmd(string name, alu_op_t op, reg_addr_t dst, reg_addr_t sa,
                             reg_addr_t sb);
        logic [33:0] e;
        int          cnt;
        int          lat;
        wait_idle();
        e = ref_result(op, shadow[sa], shadow[sb]);
        exp_q.push_back(e);
        name_q.push_back(name);
        shadow[dst] = e[31:0];
        cmd_valid = 1'b1;
        cmd = '{op: op, dst: dst, src_a: sa, src_b: sb};
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
        cnt = 0;
        while (!result_valid) begin
            @(posedge clk);
            #1;
            cnt++;
            if (cnt > 100)
                fail_run("Timeout waiting for result_valid");
        end
        lat = latency_of(op);
        if (lat != 0)
            check_value({name, " latency"}, 64'(lat), 64'(cnt));
        else if (cnt > 36)
            fail_run("Conversion took longer than 36 cycles");
    endtask

    // Comparing process
    initial begin
        logic [33:0] e;
        string       n;
        int          wait_cnt;
        wait_cnt = 0;
        forever begin
            @(posedge clk);
            #1;
            if (result_valid) begin
                if (exp_q.size() == 0)
                    fail_run("result_valid without an accepted command");
                e = exp_q.pop_front();
                n = name_q.pop_front();
                check_value(n, 64'(e), 64'({result_flag, result_data}));
                wait_cnt = 0;
            end else if (exp_q.size() != 0) begin
                wait_cnt++;
                if (wait_cnt > 100)
                    fail_run("Timeout waiting for an expected result");
            end else begin
                wait_cnt = 0;
            end
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    initial begin
        alu_op_t op;
        int      cnt;
        word_t   ftoi_pat [8];
        clk       = 1'b0;
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        lfsr_q    = 16'd53926;
        for (int i = 0; i < 16; i++)
            shadow[i] = '0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        check_value("reset busy", 64'd0, 64'(busy));
        check_value("reset result_valid", 64'd0, 64'(result_valid));
        issue_cmd("reset xor", OP_XOR, 4'd0, 4'd0, 4'd0);
        issue_cmd("reset or", OP_OR, 4'd1, 4'd3, 4'd9);

        // Logic and half-word ops
        for (int i = 0; i < 16; i++)
            load_reg(reg_addr_t'(i), rand_bits(32));
        for (int i = 0; i < 40; i++) begin
            op = alu_op_t'(4 + (rand_bits(4) % 6));
            issue_cmd("logic", op, reg_addr_t'(rand_bits(4)), reg_addr_t'(rand_bits(4)),
                      reg_addr_t'(rand_bits(4)));
        end
        issue_cmd("write-back readback", OP_OR, 4'd2, 4'd2, 4'd2);

        // Arithmetic corners
        load_reg(4'd1, 32'h7FFF_FFFF);
        load_reg(4'd2, 32'h0000_0001);
        load_reg(4'd3, 32'h8000_0000);
        load_reg(4'd4, 32'hFFFF_FFFF);
        load_reg(4'd5, 32'h0000_0000);
        issue_cmd("add overflow", OP_ADD, 4'd8, 4'd1, 4'd2);
        issue_cmd("sub overflow", OP_SUB, 4'd8, 4'd3, 4'd2);
        issue_cmd("mul overflow", OP_MUL, 4'd8, 4'd1, 4'd1);
        issue_cmd("mul negative", OP_MUL, 4'd8, 4'd3, 4'd4);
        issue_cmd("div min by -1", OP_DIV, 4'd8, 4'd3, 4'd4);
        issue_cmd("div by zero", OP_DIV, 4'd8, 4'd1, 4'd5);
        for (int i = 0; i < 30; i++) begin
            load_reg(4'd10, rand_bits(32));
            load_reg(4'd11, (i % 3 == 0) ? rand_bits(8) : rand_bits(32));
            issue_cmd("arith", alu_op_t'(rand_bits(2)), 4'd12, 4'd10, 4'd11);
        end

        // Conversions
        ftoi_pat = '{32'h7FC0_0000, 32'h7F80_0000, 32'hFF80_0000, 32'h4F00_0000,
                     32'hCF00_0000, 32'h3F00_0000, 32'hBFC0_0000, 32'h4EFF_FFFF};
        for (int i = 0; i < 8; i++) begin
            load_reg(4'd6, ftoi_pat[i]);
            issue_cmd("ftoi corner", OP_FTOI, 4'd7, 4'd6, 4'd0);
        end
        load_reg(4'd6, 32'h0100_0003);
        issue_cmd("itof round", OP_ITOF, 4'd7, 4'd6, 4'd0);
        issue_cmd("itof min", OP_ITOF, 4'd7, 4'd3, 4'd0);
        issue_cmd("itof zero", OP_ITOF, 4'd7, 4'd5, 4'd0);
        for (int i = 0; i < 30; i++) begin
            load_reg(4'd6, rand_bits(32) >> rand_bits(4));
            issue_cmd("itof", OP_ITOF, 4'd7, 4'd6, 4'd0);
            load_reg(4'd6, rand_bits(32));
            issue_cmd("ftoi", OP_FTOI, 4'd7, 4'd6, 4'd0);
        end

        // Commands offered while busy are dropped
        load_reg(4'd13, 32'h1234_5678);
        wait_idle();
        exp_q.push_back(ref_result(OP_MUL, shadow[1], shadow[2]));
        name_q.push_back("busy mul");
        shadow[14] = shadow[1] * shadow[2];
        cmd_valid = 1'b1;
        cmd = '{op: OP_MUL, dst: 4'd14, src_a: 4'd1, src_b: 4'd2};
        @(posedge clk);
        #1;
        cmd = '{op: OP_NOT, dst: 4'd13, src_a: 4'd4, src_b: 4'd4};
        repeat (5) @(posedge clk);
        #1;
        cmd_valid = 1'b0;
        cnt = 0;
        while (!result_valid) begin
            @(posedge clk);
            #1;
            cnt++;
            if (cnt > 100)
                fail_run("Timeout waiting for result_valid on busy test");
        end
        issue_cmd("dropped command target", OP_OR, 4'd0, 4'd13, 4'd13);

        // Mixed random commands
        for (int i = 0; i < 40; i++)
            issue_cmd("mixed", alu_op_t'(rand_bits(4)), reg_addr_t'(rand_bits(4)),
                      reg_addr_t'(rand_bits(4)), reg_addr_t'(rand_bits(4)));

        repeat (5) @(posedge clk);
        #1;
        if (exp_q.size() != 0) begin
            $display("Results missing at end of run");
            $display("** FAIL **");
            $fatal(1, "Simulation stopped");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verification/int_exec_unit_chk.sv
/* Bound assertions on result_valid, busy and result flags */
`timescale 1ns/1ps
`default_nettype none

module int_exec_unit_chk import alu_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      busy,
    input logic      result_valid,
    input alu_flag_t result_flag,
    input alu_op_t   op
);

    // One pulse per result
    a_valid_pulse: assert property (@(posedge clk) disable iff (reset)
        result_valid |=> !result_valid)
        else $error("result_valid high two cycles in a row");

    a_busy_drop: assert property (@(posedge clk) disable iff (reset)
        result_valid |-> !busy)
        else $error("busy still high with result_valid");

    // Logic, half-word and conversion ops carry no flags
    a_flag_zero: assert property (@(posedge clk) disable iff (reset)
        (result_valid && op[3:2] != 2'b00) |-> result_flag == '0)
        else $error("nonzero flags on a non-arithmetic result");

endmodule

bind int_exec_unit int_exec_unit_chk chk (
    .clk          (clk),
    .reset        (reset),
    .busy         (busy),
    .result_valid (result_valid),
    .result_flag  (result_flag),
    .op           (cmd_q.op)
);

`default_nettype wire

//--- rtl/int_exec_unit.sv
/* Execution unit top: command capture, operand latching,
   ALU enable control, write-back and register load port */
`timescale 1ns/1ps
`default_nettype none

module int_exec_unit import alu_pkg::*; #(
    parameter int NUM_REGS = 16
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      cmd_valid,
    input  exec_cmd_t cmd,
    input  logic      load_en,
    input  reg_addr_t load_addr,
    input  word_t     load_data,
    output logic      busy,
    output logic      result_valid,
    output word_t     result_data,
    output alu_flag_t result_flag
);

    typedef enum logic [1:0] {EX_IDLE, EX_ISSUE, EX_RUN} ex_state_t;

    ex_state_t state;
    exec_cmd_t cmd_q;
    word_t     op_a_q;
    word_t     op_b_q;
    word_t     rd_a;
    word_t     rd_b;
    logic      accept;
    logic      alu_en;
    logic      alu_done;
    logic      alu_knock;
    logic      wb_fire;
    word_t     alu_out;
    alu_flag_t alu_flag;
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;

    assign busy    = state != EX_IDLE;
    // Commands offered while busy are dropped
    assign accept  = cmd_valid && !busy;
    assign alu_en  = state == EX_RUN;
    assign wb_fire = alu_en && alu_knock && alu_done;

    // Write-back wins the single write port over loads
    assign wr_en   = wb_fire || load_en;
    assign wr_addr = wb_fire ? cmd_q.dst : load_addr;
    assign wr_data = wb_fire ? alu_out : load_data;

    reg_file #(
        .NUM_REGS (NUM_REGS)
    ) u_regs (
        .clk       (clk),
        .reset     (reset),
        .rd_addr_a (cmd.src_a),
        .rd_addr_b (cmd.src_b),
        .rd_data_a (rd_a),
        .rd_data_b (rd_b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    int_alu u_alu (
        .clk           (clk),
        .reset         (reset),
        .en            (alu_en),
        .operation     (cmd_q.op),
        .op1           (op_a_q),
        .op2           (op_b_q),
        .out           (alu_out),
        .flag          (alu_flag),
        .done          (alu_done),
        .en_knock_down (alu_knock)
    );

    //////////////////////////////
    // Command sequencing
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= EX_IDLE;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            case (state)
                EX_IDLE:  if (accept) state <= EX_ISSUE;
                EX_ISSUE: state <= EX_RUN;
                EX_RUN: begin
                    if (wb_fire) begin
                        state        <= EX_IDLE;
                        result_valid <= 1'b1;
                    end
                end
                default:  state <= EX_IDLE;
            endcase
        end
    end

    // Operands stay put until the ALU is finished
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q  <= cmd;
            op_a_q <= rd_a;
            op_b_q <= rd_b;
        end
        if (wb_fire) begin
            result_data <= alu_out;
            result_flag <= alu_flag;
        end
    end

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
/* Register file, two combinational read ports and one synchronous write port */
`timescale 1ns/1ps
`default_nettype none

module reg_file import alu_pkg::*; #(
    parameter int NUM_REGS = 16
) (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rd_addr_a,
    input  reg_addr_t rd_addr_b,
    output word_t     rd_data_a,
    output word_t     rd_data_b,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data
);

    word_t regs [NUM_REGS];

    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

//--- rtl/int_alu.sv
/* Integer ALU: opcode decode, logic and half-word ops,
   enable and result steering for the three functional units */
`timescale 1ns/1ps
`default_nettype none

module int_alu import alu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      en,
    input  alu_op_t   operation,
    input  word_t     op1,
    input  word_t     op2,
    output word_t     out,
    output alu_flag_t flag,
    output logic      done,
    output logic      en_knock_down
);

    alu_op_t   op_w;
    dword_t    md_out;
    alu_flag_t md_flag;
    logic      md_done;
    logic      md_en;
    word_t     itof_out;
    word_t     ftoi_out;
    logic      itof_done;
    logic      ftoi_done;
    logic      itof_en;
    logic      ftoi_en;

    // 11xx decodes as the 10xx special group
    assign op_w = operation[3] ? {2'b10, operation[1:0]} : operation;

    int_muldiv u_muldiv (
        .clk       (clk),
        .reset     (reset),
        .en        (md_en),
        .operation (op_w[1:0]),
        .op1_in    (op1),
        .op2_in    (op2),
        .out       (md_out),
        .flag      (md_flag),
        .done      (md_done)
    );

    int_to_float u_itof (
        .clk   (clk),
        .reset (reset),
        .en    (itof_en),
        .in_in (op1),
        .out   (itof_out),
        .done  (itof_done)
    );

    float_to_int u_ftoi (
        .clk   (clk),
        .reset (reset),
        .en    (ftoi_en),
        .in_in (op1),
        .out   (ftoi_out),
        .done  (ftoi_done)
    );

    // Combinational groups report done at once
    always_comb begin
        md_en         = 1'b0;
        itof_en       = 1'b0;
        ftoi_en       = 1'b0;
        en_knock_down = 1'b1;
        done          = 1'b1;
        flag          = '0;
        out           = op1;
        case (op_w)
            OP_ADD, OP_SUB, OP_MUL, OP_DIV: begin
                md_en         = en;
                en_knock_down = en;
                done          = md_done;
                out           = md_out[31:0];
                flag          = md_flag;
            end
            OP_NOT:        out = ~op1;
            OP_AND:        out = op1 & op2;
            OP_OR:         out = op1 | op2;
            OP_XOR:        out = op1 ^ op2;
            OP_WRITE_HIGH: out = {op2[15:0], op1[15:0]};
            OP_WRITE_LOW:  out = {op1[31:16], op2[15:0]};
            OP_ITOF: begin
                itof_en       = en;
                en_knock_down = en;
                done          = itof_done;
                out           = itof_out;
            end
            OP_FTOI: begin
                ftoi_en       = en;
                en_knock_down = en;
                done          = ftoi_done;
                out           = ftoi_out;
            end
            default: out = op1;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/float_to_int.sv
/* IEEE single to signed integer conversion with truncation
   and saturation */
`timescale 1ns/1ps
`default_nettype none

module float_to_int import alu_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  en,
    input  word_t in_in,
    output word_t out,
    output logic  done
);

    typedef enum logic {FI_IDLE, FI_HOLD} fi_state_t;

    fi_state_t  state;
    logic [7:0] exp_w;
    logic [7:0] shift_w;
    word_t      mag_w;
    word_t      conv_w;

    assign exp_w   = in_in[30:23];
    // 31 minus the unbiased exponent
    assign shift_w = 8'd158 - exp_w;
    assign mag_w   = {1'b1, in_in[22:0], 8'd0} >> shift_w;

    always_comb begin
        if (exp_w == 8'hFF && in_in[22:0] != '0)
            conv_w = 32'h7FFF_FFFF;
        else if (exp_w < 8'd127)
            conv_w = '0;
        else if (exp_w >= 8'd158)
            conv_w = in_in[31] ? 32'h8000_0000 : 32'h7FFF_FFFF;
        else
            conv_w = in_in[31] ? -mag_w : mag_w;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FI_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (state == FI_IDLE && en) begin
                state <= FI_HOLD;
                done  <= 1'b1;
            end else if (state == FI_HOLD && !en) begin
                state <= FI_IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == FI_IDLE && en)
            out <= conv_w;
    end

endmodule

`default_nettype wire

//--- rtl/int_to_float.sv
/* Signed integer to IEEE single conversion by iterative
   normalization, round to nearest even */
`timescale 1ns/1ps
`default_nettype none

module int_to_float import alu_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  en,
    input  word_t in_in,
    output word_t out,
    output logic  done
);

    typedef enum logic [1:0] {IF_IDLE, IF_NORM, IF_FINISH} if_state_t;

    if_state_t   state;
    word_t       mag_q;
    logic [7:0]  exp_q;
    logic        sign_q;
    logic        round_up_w;
    logic [30:0] packed_w;

    // Guard bit with sticky or odd lsb, carry may ripple into the exponent
    assign round_up_w = mag_q[7] & (mag_q[8] | (|mag_q[6:0]));
    assign packed_w   = {exp_q, mag_q[30:8]} + 31'(round_up_w);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IF_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IF_IDLE: begin
                    if (en && in_in == '0) begin
                        state <= IF_FINISH;
                        done  <= 1'b1;
                    end else if (en) begin
                        state <= IF_NORM;
                    end
                end
                IF_NORM: begin
                    if (mag_q[31]) begin
                        state <= IF_FINISH;
                        done  <= 1'b1;
                    end
                end
                IF_FINISH: begin
                    if (!en)
                        state <= IF_IDLE;
                end
                default: state <= IF_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IF_IDLE && en) begin
            sign_q <= in_in[31];
            mag_q  <= in_in[31] ? -in_in : in_in;
            // 127 + 31, top bit of the word
            exp_q  <= 8'd158;
            out    <= '0;
        end else if (state == IF_NORM) begin
            if (mag_q[31]) begin
                out <= {sign_q, packed_w};
            end else begin
                mag_q <= mag_q << 1;
                exp_q <= exp_q - 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/int_muldiv.sv
/* Add/sub, shift-add multiply and restoring signed divide
   with overflow and divide-by-zero flags */
`timescale 1ns/1ps
`default_nettype none

module int_muldiv import alu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       en,
    input  logic [1:0] operation,
    input  word_t      op1_in,
    input  word_t      op2_in,
    output dword_t     out,
    output alu_flag_t  flag,
    output logic       done
);

    typedef enum logic [1:0] {MD_IDLE, MD_RUN, MD_FINISH} md_state_t;

    md_state_t   state;
    logic [4:0]  step_cnt;
    logic        is_div_q;
    logic        neg_q;
    logic        div_zero_q;
    word_t       mag_q;
    dword_t      acc_q;
    dword_t      res_q;
    alu_flag_t   flag_q;

    word_t       sum_w;
    word_t       diff_w;
    word_t       mag1_w;
    word_t       mag2_w;
    logic [32:0] add_w;
    logic [32:0] trial_w;
    dword_t      step_w;
    dword_t      fix_w;
    dword_t      fin_res_w;
    alu_flag_t   fin_flag_w;

    assign sum_w  = op1_in + op2_in;
    assign diff_w = op1_in - op2_in;
    assign mag1_w = op1_in[31] ? -op1_in : op1_in;
    assign mag2_w = op2_in[31] ? -op2_in : op2_in;

    //////////////////////////////
    // One multiply or divide step
    //////////////////////////////
    assign add_w   = {1'b0, acc_q[63:32]} + {1'b0, mag_q};
    assign trial_w = {1'b0, acc_q[62:31]} - {1'b0, mag_q};

    always_comb begin
        if (is_div_q) begin
            // Restore when the trial subtract goes negative
            if (!trial_w[32])
                step_w = {trial_w[31:0], acc_q[30:0], 1'b1};
            else
                step_w = {acc_q[62:0], 1'b0};
        end else if (acc_q[0]) begin
            step_w = {add_w, acc_q[31:1]};
        end else begin
            step_w = {1'b0, acc_q[63:1]};
        end
    end

    assign fix_w = neg_q ? -step_w : step_w;

    // Final result and flags after the last step
    always_comb begin
        fin_flag_w = '0;
        if (!is_div_q) begin
            fin_res_w = fix_w;
            fin_flag_w[FLAG_OVF] = fix_w[63:32] != {32{fix_w[31]}};
        end else if (div_zero_q) begin
            fin_res_w = '1;
            fin_flag_w[FLAG_DZ] = 1'b1;
        end else begin
            fin_res_w = {{32{fix_w[31]}}, fix_w[31:0]};
            // Only MIN / -1 lands here
            fin_flag_w[FLAG_OVF] = step_w[31] & ~neg_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= MD_IDLE;
            step_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                MD_IDLE: begin
                    if (en && !operation[1]) begin
                        state <= MD_FINISH;
                        done  <= 1'b1;
                    end else if (en) begin
                        state    <= MD_RUN;
                        step_cnt <= '0;
                    end
                end
                MD_RUN: begin
                    step_cnt <= step_cnt + 5'd1;
                    if (step_cnt == 5'd31) begin
                        state <= MD_FINISH;
                        done  <= 1'b1;
                    end
                end
                MD_FINISH: begin
                    if (!en)
                        state <= MD_IDLE;
                end
                default: state <= MD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == MD_IDLE && en) begin
            is_div_q   <= operation == OP_DIV[1:0];
            neg_q      <= op1_in[31] ^ op2_in[31];
            div_zero_q <= op2_in == '0;
            mag_q      <= (operation == OP_DIV[1:0]) ? mag2_w : mag1_w;
            acc_q      <= {32'd0, (operation == OP_DIV[1:0]) ? mag1_w : mag2_w};
            if (operation == OP_ADD[1:0]) begin
                res_q  <= {{32{sum_w[31]}}, sum_w};
                flag_q <= {1'b0, (op1_in[31] == op2_in[31]) && (sum_w[31] != op1_in[31])};
            end else if (operation == OP_SUB[1:0]) begin
                res_q  <= {{32{diff_w[31]}}, diff_w};
                flag_q <= {1'b0, (op1_in[31] != op2_in[31]) && (diff_w[31] != op1_in[31])};
            end
        end else if (state == MD_RUN) begin
            acc_q <= step_w;
            if (step_cnt == 5'd31) begin
                res_q  <= fin_res_w;
                flag_q <= fin_flag_w;
            end
        end
    end

    assign out  = res_q;
    assign flag = flag_q;

endmodule

`default_nettype wire

//--- rtl/alu_pkg.sv
/* Operand, opcode, register index and flag types, opcode constants
   and the command struct of the execution unit */
`default_nettype none

package alu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [3:0]  reg_addr_t;
    typedef logic [1:0]  alu_flag_t;

    // Flag bit positions
    localparam int FLAG_OVF = 0;
    localparam int FLAG_DZ  = 1;

    //////////////////////////////
    // Opcodes, group in the top two bits
    //////////////////////////////
    // 00xx arithmetic
    localparam alu_op_t OP_ADD        = 4'b0000;
    localparam alu_op_t OP_SUB        = 4'b0001;
    localparam alu_op_t OP_MUL        = 4'b0010;
    localparam alu_op_t OP_DIV        = 4'b0011;
    // 01xx logic
    localparam alu_op_t OP_NOT        = 4'b0100;
    localparam alu_op_t OP_AND        = 4'b0101;
    localparam alu_op_t OP_OR         = 4'b0110;
    localparam alu_op_t OP_XOR        = 4'b0111;
    // 1xxx special, 11xx aliases 10xx
    localparam alu_op_t OP_WRITE_HIGH = 4'b1000;
    localparam alu_op_t OP_WRITE_LOW  = 4'b1001;
    localparam alu_op_t OP_ITOF       = 4'b1010;
    localparam alu_op_t OP_FTOI       = 4'b1011;

    typedef struct packed {
        alu_op_t   op;
        reg_addr_t dst;
        reg_addr_t src_a;
        reg_addr_t src_b;
    } exec_cmd_t;

endpackage

`default_nettype wire
